// ==== compile.f ====
logic/axis_pkg.sv
logic/axis_ingress_slice.sv
logic/axis_length_tagger.sv
logic/axis_stream_monitor.sv
logic/axis_policer_top.sv
test/tb_axis_policer_top.sv

// ==== logic/axis_ingress_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_ingress_slice #(
	parameter int DATA_BYTES = 4,
	parameter int ID_W       = 2,
	parameter int DEST_W     = 2,
	parameter int USER_W     = 1
) (
	input  wire                      i_aclk,
	input  wire                      i_aresetn,
	// Upstream side
	input  wire                      i_tvalid,
	output logic                     o_tready,
	input  wire  [8*DATA_BYTES-1:0]  i_tdata,
	input  wire  [DATA_BYTES-1:0]    i_tkeep,
	input  wire  [DATA_BYTES-1:0]    i_tstrb,
	input  wire                      i_tlast,
	input  wire  [ID_W-1:0]          i_tid,
	input  wire  [DEST_W-1:0]        i_tdest,
	input  wire  [USER_W-1:0]        i_tuser,
	// Downstream side
	output logic                     o_tvalid,
	input  wire                      i_ready,
	output logic [8*DATA_BYTES-1:0]  o_tdata,
	output logic [DATA_BYTES-1:0]    o_tkeep,
	output logic [DATA_BYTES-1:0]    o_tstrb,
	output logic                     o_tlast,
	output logic [ID_W-1:0]          o_tid,
	output logic [DEST_W-1:0]        o_tdest,
	output logic [USER_W-1:0]        o_tuser
);

	// One beat packed as data, keep, strobe, last and the sidebands
	localparam int BEAT_W = 8*DATA_BYTES + 2*DATA_BYTES + 1 + ID_W + DEST_W + USER_W;

	logic [BEAT_W-1:0] in_beat;
	logic [BEAT_W-1:0] main_q;
	logic [BEAT_W-1:0] skid_q;
	logic              main_valid_q;
	logic              skid_valid_q;
	logic              ready_q;
	logic              in_fire;
	logic              out_fire;
	logic              main_load;
	logic              skid_load;

	assign in_beat = {i_tdata, i_tkeep, i_tstrb, i_tlast, i_tid, i_tdest, i_tuser};

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	// The ready seen by the source comes straight from a flop
	assign o_tready = ready_q;
	assign in_fire  = i_tvalid && ready_q;
	assign out_fire = main_valid_q && i_ready;

	// The main register takes a beat when it is empty or draining this cycle
	assign main_load = !main_valid_q || out_fire;

	// A beat that arrives while the output is stuck goes to the skid entry
	assign skid_load = in_fire && !main_load;

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
		begin
			main_valid_q <= 1'b0;
			skid_valid_q <= 1'b0;
			ready_q      <= 1'b0;
		end
		else
		begin
			// The skid entry has priority so that order is kept
			if (main_load)
				main_valid_q <= skid_valid_q || in_fire;
			if (main_load)
				skid_valid_q <= 1'b0;
			else if (skid_load)
				skid_valid_q <= 1'b1;
			// Ready is low exactly while the skid entry holds a beat
			ready_q <= !(skid_load || (skid_valid_q && !main_load));
		end
	end

	////////////////////////////////////////
	// Payload
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (main_load)
			main_q <= skid_valid_q ? skid_q : in_beat;
		if (skid_load)
			skid_q <= in_beat;
	end

	assign o_tvalid = main_valid_q;
	assign {o_tdata, o_tkeep, o_tstrb, o_tlast, o_tid, o_tdest, o_tuser} = main_q;

	// A stalled output beat must be held unchanged into the next cycle
	a_out_stable: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		main_valid_q && !i_ready |=> main_valid_q && $stable(main_q))
		else $error("slice output changed while stalled");

endmodule

`default_nettype wire

// ==== logic/axis_length_tagger.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_length_tagger #(
	parameter int DATA_BYTES = 4,
	parameter int ID_W       = 2,
	parameter int DEST_W     = 2,
	parameter int USER_W     = 1,
	parameter int MIN_PKT    = 4,
	parameter int MAX_PKT    = 64
) (
	input  wire                             i_aclk,
	input  wire                             i_aresetn,
	// Stream from the ingress slice
	input  wire                             i_tvalid,
	output logic                            o_tready,
	input  wire  [8*DATA_BYTES-1:0]         i_tdata,
	input  wire  [DATA_BYTES-1:0]           i_tkeep,
	input  wire  [DATA_BYTES-1:0]           i_tstrb,
	input  wire                             i_tlast,
	input  wire  [ID_W-1:0]                 i_tid,
	input  wire  [DEST_W-1:0]               i_tdest,
	input  wire  [USER_W-1:0]               i_tuser,
	// Master stream
	output logic                            o_tvalid,
	input  wire                             i_m_tready,
	output logic [8*DATA_BYTES-1:0]         o_tdata,
	output logic [DATA_BYTES-1:0]           o_tkeep,
	output logic [DATA_BYTES-1:0]           o_tstrb,
	output logic                            o_tlast,
	output logic [ID_W-1:0]                 o_tid,
	output logic [DEST_W-1:0]               o_tdest,
	output logic [USER_W-1:0]               o_tuser,
	output logic [axis_pkg::LEN_W-1:0]      o_tlen,
	output logic                            o_tlen_err
);

	axis_pkg::tag_state_e state_q;

	logic [axis_pkg::LEN_W-1:0] run_len_q;
	logic [axis_pkg::LEN_W-1:0] beat_bytes;
	logic [axis_pkg::LEN_W-1:0] len_sum;
	logic                       take;
	logic                       len_bad;

	////////////////////////////////////////
	// Byte counting
	////////////////////////////////////////

	// Only bytes with both TKEEP and TSTRB high carry data
	always_comb
	begin
		beat_bytes = '0;
		for (int b = 0; b < DATA_BYTES; b++)
		begin
			if (i_tkeep[b] && i_tstrb[b])
				beat_bytes = beat_bytes + 1'b1;
		end
	end

	// The first beat of a packet ignores whatever the running sum holds
	assign len_sum = ((state_q == axis_pkg::TAG_IDLE) ? '0 : run_len_q) + beat_bytes;
	assign len_bad = (len_sum < MIN_PKT) || (len_sum > MAX_PKT);

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	// Accept when the output register is empty or is being read this cycle
	assign o_tready = !o_tvalid || i_m_tready;
	assign take     = i_tvalid && o_tready;

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
		begin
			o_tvalid   <= 1'b0;
			o_tlen_err <= 1'b0;
			run_len_q  <= '0;
			state_q    <= axis_pkg::TAG_IDLE;
		end
		else
		begin
			if (o_tready)
				o_tvalid <= i_tvalid;
			if (take)
			begin
				// The flag only ever rides on a last beat
				o_tlen_err <= i_tlast && len_bad;
				run_len_q  <= len_sum;
				state_q    <= i_tlast ? axis_pkg::TAG_IDLE : axis_pkg::TAG_IN_PKT;
			end
		end
	end

	always_ff @(posedge i_aclk)
	begin
		if (take)
		begin
			o_tdata <= i_tdata;
			o_tkeep <= i_tkeep;
			o_tstrb <= i_tstrb;
			o_tlast <= i_tlast;
			o_tid   <= i_tid;
			o_tdest <= i_tdest;
			o_tuser <= i_tuser;
			// Length is reported on the last beat and reads zero elsewhere
			o_tlen  <= i_tlast ? len_sum : '0;
		end
	end

	// A length error is always attached to the end of a packet
	a_err_on_last: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		o_tvalid && o_tlen_err |-> o_tlast)
		else $error("length error flagged on a beat without TLAST");

endmodule

`default_nettype wire

// ==== logic/axis_pkg.sv ====
`default_nettype none

package axis_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Width of a packet byte count, also used for the stall counters
	localparam int LEN_W = 16;

	// Number of sticky flags in a monitor error vector
	localparam int ERR_COUNT = 4;

	////////////////////////////////////////
	// Monitor error bits
	////////////////////////////////////////

	// Each value is the bit position of its flag inside o_err
	typedef enum logic [1:0] {
		// Payload changed or TVALID fell while the beat was stalled
		ERR_UNSTABLE    = 2'd0,
		// A byte had TSTRB high with TKEEP low
		ERR_RESERVED    = 2'd1,
		// A stall lasted MAX_STALL cycles or more
		ERR_STALL       = 2'd2,
		// TVALID was high in the first cycle after reset
		ERR_RESET_VALID = 2'd3
	} mon_err_e;

	////////////////////////////////////////
	// Length stage FSM
	////////////////////////////////////////

	typedef enum logic {
		// Next accepted beat starts a new packet
		TAG_IDLE   = 1'b0,
		// At least one beat of the current packet has passed
		TAG_IN_PKT = 1'b1
	} tag_state_e;

endpackage

`default_nettype wire

// ==== logic/axis_policer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_policer_top #(
	parameter int DATA_BYTES = 4,
	parameter int ID_W       = 2,
	parameter int DEST_W     = 2,
	parameter int USER_W     = 1,
	parameter int MIN_PKT    = 4,
	parameter int MAX_PKT    = 64,
	parameter int MAX_STALL  = 16
) (
	input  wire                              i_aclk,
	input  wire                              i_aresetn,
	// Slave port
	input  wire                              i_s_tvalid,
	output logic                             o_s_tready,
	input  wire  [8*DATA_BYTES-1:0]          i_s_tdata,
	input  wire  [DATA_BYTES-1:0]            i_s_tkeep,
	input  wire  [DATA_BYTES-1:0]            i_s_tstrb,
	input  wire                              i_s_tlast,
	input  wire  [ID_W-1:0]                  i_s_tid,
	input  wire  [DEST_W-1:0]                i_s_tdest,
	input  wire  [USER_W-1:0]                i_s_tuser,
	// Master port with length tag
	output logic                             o_m_tvalid,
	input  wire                              i_m_tready,
	output logic [8*DATA_BYTES-1:0]          o_m_tdata,
	output logic [DATA_BYTES-1:0]            o_m_tkeep,
	output logic [DATA_BYTES-1:0]            o_m_tstrb,
	output logic                             o_m_tlast,
	output logic [ID_W-1:0]                  o_m_tid,
	output logic [DEST_W-1:0]                o_m_tdest,
	output logic [USER_W-1:0]                o_m_tuser,
	output logic [axis_pkg::LEN_W-1:0]       o_m_tlen,
	output logic                             o_m_tlen_err,
	// Monitor results
	input  wire  [DEST_W+ID_W-1:0]           i_route_sel,
	output logic [axis_pkg::LEN_W-1:0]       o_in_bytecount,
	output logic [axis_pkg::ERR_COUNT-1:0]   o_in_err,
	output logic [axis_pkg::ERR_COUNT-1:0]   o_out_err
);

	// Stream A runs from the slice to the tagger
	logic                    a_tvalid;
	logic                    a_tready;
	logic [8*DATA_BYTES-1:0] a_tdata;
	logic [DATA_BYTES-1:0]   a_tkeep;
	logic [DATA_BYTES-1:0]   a_tstrb;
	logic                    a_tlast;
	logic [ID_W-1:0]         a_tid;
	logic [DEST_W-1:0]       a_tdest;
	logic [USER_W-1:0]       a_tuser;

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	axis_ingress_slice #(
		.DATA_BYTES (DATA_BYTES),
		.ID_W       (ID_W),
		.DEST_W     (DEST_W),
		.USER_W     (USER_W)
	) u_slice (
		.i_aclk    (i_aclk),
		.i_aresetn (i_aresetn),
		.i_tvalid  (i_s_tvalid),
		.o_tready  (o_s_tready),
		.i_tdata   (i_s_tdata),
		.i_tkeep   (i_s_tkeep),
		.i_tstrb   (i_s_tstrb),
		.i_tlast   (i_s_tlast),
		.i_tid     (i_s_tid),
		.i_tdest   (i_s_tdest),
		.i_tuser   (i_s_tuser),
		.o_tvalid  (a_tvalid),
		.i_ready   (a_tready),
		.o_tdata   (a_tdata),
		.o_tkeep   (a_tkeep),
		.o_tstrb   (a_tstrb),
		.o_tlast   (a_tlast),
		.o_tid     (a_tid),
		.o_tdest   (a_tdest),
		.o_tuser   (a_tuser)
	);

	axis_length_tagger #(
		.DATA_BYTES (DATA_BYTES),
		.ID_W       (ID_W),
		.DEST_W     (DEST_W),
		.USER_W     (USER_W),
		.MIN_PKT    (MIN_PKT),
		.MAX_PKT    (MAX_PKT)
	) u_tagger (
		.i_aclk     (i_aclk),
		.i_aresetn  (i_aresetn),
		.i_tvalid   (a_tvalid),
		.o_tready   (a_tready),
		.i_tdata    (a_tdata),
		.i_tkeep    (a_tkeep),
		.i_tstrb    (a_tstrb),
		.i_tlast    (a_tlast),
		.i_tid      (a_tid),
		.i_tdest    (a_tdest),
		.i_tuser    (a_tuser),
		.o_tvalid   (o_m_tvalid),
		.i_m_tready (i_m_tready),
		.o_tdata    (o_m_tdata),
		.o_tkeep    (o_m_tkeep),
		.o_tstrb    (o_m_tstrb),
		.o_tlast    (o_m_tlast),
		.o_tid      (o_m_tid),
		.o_tdest    (o_m_tdest),
		.o_tuser    (o_m_tuser),
		.o_tlen     (o_m_tlen),
		.o_tlen_err (o_m_tlen_err)
	);

	////////////////////////////////////////
	// Monitors
	////////////////////////////////////////

	// Input side sees the ready that the slice hands to the source
	axis_stream_monitor #(
		.DATA_BYTES (DATA_BYTES),
		.ID_W       (ID_W),
		.DEST_W     (DEST_W),
		.USER_W     (USER_W),
		.MAX_STALL  (MAX_STALL)
	) u_mon_in (
		.i_aclk      (i_aclk),
		.i_aresetn   (i_aresetn),
		.i_tvalid    (i_s_tvalid),
		.i_tready    (o_s_tready),
		.i_tdata     (i_s_tdata),
		.i_tkeep     (i_s_tkeep),
		.i_tstrb     (i_s_tstrb),
		.i_tlast     (i_s_tlast),
		.i_tid       (i_s_tid),
		.i_tdest     (i_s_tdest),
		.i_tuser     (i_s_tuser),
		.i_route_sel (i_route_sel),
		.o_bytecount (o_in_bytecount),
		.o_err       (o_in_err)
	);

	// Output side only reports errors, its byte count is not brought out
	axis_stream_monitor #(
		.DATA_BYTES (DATA_BYTES),
		.ID_W       (ID_W),
		.DEST_W     (DEST_W),
		.USER_W     (USER_W),
		.MAX_STALL  (MAX_STALL)
	) u_mon_out (
		.i_aclk      (i_aclk),
		.i_aresetn   (i_aresetn),
		.i_tvalid    (o_m_tvalid),
		.i_tready    (i_m_tready),
		.i_tdata     (o_m_tdata),
		.i_tkeep     (o_m_tkeep),
		.i_tstrb     (o_m_tstrb),
		.i_tlast     (o_m_tlast),
		.i_tid       (o_m_tid),
		.i_tdest     (o_m_tdest),
		.i_tuser     (o_m_tuser),
		.i_route_sel (i_route_sel),
		.o_bytecount (),
		.o_err       (o_out_err)
	);

endmodule

`default_nettype wire

// ==== logic/axis_stream_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_stream_monitor #(
	parameter int DATA_BYTES = 4,
	parameter int ID_W       = 2,
	parameter int DEST_W     = 2,
	parameter int USER_W     = 1,
	parameter int MAX_STALL  = 16
) (
	input  wire                              i_aclk,
	input  wire                              i_aresetn,
	// Tapped stream that is only observed
	input  wire                              i_tvalid,
	input  wire                              i_tready,
	input  wire  [8*DATA_BYTES-1:0]          i_tdata,
	input  wire  [DATA_BYTES-1:0]            i_tkeep,
	input  wire  [DATA_BYTES-1:0]            i_tstrb,
	input  wire                              i_tlast,
	input  wire  [ID_W-1:0]                  i_tid,
	input  wire  [DEST_W-1:0]                i_tdest,
	input  wire  [USER_W-1:0]                i_tuser,
	// Route whose packet bytes are counted, as {TDEST, TID}
	input  wire  [DEST_W+ID_W-1:0]           i_route_sel,
	output logic [axis_pkg::LEN_W-1:0]       o_bytecount,
	output logic [axis_pkg::ERR_COUNT-1:0]   o_err
);

	// Copy of the previous cycle's beat, compared against while stalled
	logic [8*DATA_BYTES-1:0]    prev_data;
	logic [DATA_BYTES-1:0]      prev_keep;
	logic [DATA_BYTES-1:0]      prev_strb;
	logic                       prev_last;
	logic [ID_W-1:0]            prev_id;
	logic [DEST_W-1:0]          prev_dest;
	logic [USER_W-1:0]          prev_user;
	logic                       prev_stall;
	logic                       after_rst;

	logic [axis_pkg::LEN_W-1:0] stall_cnt;
	logic [axis_pkg::LEN_W-1:0] beat_bytes;
	logic                       stalled;
	logic                       data_moved;
	logic                       unstable;
	logic                       reserved;
	logic                       route_hit;

	assign stalled   = i_tvalid && !i_tready;
	assign route_hit = ({i_tdest, i_tid} == i_route_sel);

	////////////////////////////////////////
	// Beat checks
	////////////////////////////////////////

	// Bytes dropped by TKEEP are null, so their data may change freely
	always_comb
	begin
		data_moved = 1'b0;
		for (int b = 0; b < DATA_BYTES; b++)
		begin
			if (prev_keep[b] && (i_tdata[8*b +: 8] != prev_data[8*b +: 8]))
				data_moved = 1'b1;
		end
	end

	// A stalled beat must stay valid and keep every field
	assign unstable = prev_stall && (!i_tvalid || data_moved
		|| (i_tkeep != prev_keep) || (i_tstrb != prev_strb)
		|| (i_tlast != prev_last) || (i_tid != prev_id)
		|| (i_tdest != prev_dest) || (i_tuser != prev_user));

	// TSTRB high with TKEEP low is a reserved byte type
	assign reserved = i_tvalid && ((i_tstrb & ~i_tkeep) != '0);

	// Valid bytes of this beat, for the route byte count
	always_comb
	begin
		beat_bytes = '0;
		for (int b = 0; b < DATA_BYTES; b++)
		begin
			if (i_tkeep[b] && i_tstrb[b])
				beat_bytes = beat_bytes + 1'b1;
		end
	end

	////////////////////////////////////////
	// State and sticky flags
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (!i_aresetn)
		begin
			o_err       <= '0;
			o_bytecount <= '0;
			stall_cnt   <= '0;
			prev_stall  <= 1'b0;
			after_rst   <= 1'b1;
		end
		else
		begin
			after_rst  <= 1'b0;
			prev_stall <= stalled;
			if (unstable)
				o_err[axis_pkg::ERR_UNSTABLE] <= 1'b1;
			if (reserved)
				o_err[axis_pkg::ERR_RESERVED] <= 1'b1;
			// The source should keep TVALID low right out of reset
			if (after_rst && i_tvalid)
				o_err[axis_pkg::ERR_RESET_VALID] <= 1'b1;
			// Stall length saturates at the limit
			if (!stalled)
				stall_cnt <= '0;
			else if (stall_cnt < MAX_STALL)
				stall_cnt <= stall_cnt + 1'b1;
			if (stalled && (stall_cnt >= MAX_STALL - 1))
				o_err[axis_pkg::ERR_STALL] <= 1'b1;
			if (i_tvalid && i_tready && route_hit)
			begin
				if (i_tlast)
					o_bytecount <= '0;
				else
					o_bytecount <= o_bytecount + beat_bytes;
			end
		end
	end

	// Every field is copied each cycle for the stability check
	always_ff @(posedge i_aclk)
	begin
		prev_data <= i_tdata;
		prev_keep <= i_tkeep;
		prev_strb <= i_tstrb;
		prev_last <= i_tlast;
		prev_id   <= i_tid;
		prev_dest <= i_tdest;
		prev_user <= i_tuser;
	end

	// The stall flag can only appear after MAX_STALL stalled edges in a row
	a_stall_flag: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
		$rose(o_err[axis_pkg::ERR_STALL]) |-> $past(stalled, MAX_STALL))
		else $error("stall flag raised without a full stall");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run the testbench and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_policer_top -f compile.f \
	&& obj_dir/Vtb_axis_policer_top | tee /dev/stderr | grep -x "Simulation PASSED" > /dev/null \
	&& echo "run_sim.sh: pass" \
	|| { echo "run_sim.sh: fail"; exit 1; }

// ==== test/tb_axis_policer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axis_policer_top;

	localparam int DATA_BYTES = 4;
	localparam int ID_W       = 2;
	localparam int DEST_W     = 2;
	localparam int USER_W     = 1;
	localparam int MIN_PKT    = 4;
	localparam int MAX_PKT    = 64;
	localparam int MAX_STALL  = 16;
	localparam int ROUTE_W    = DEST_W + ID_W;
	localparam int BEAT_W     = 8*DATA_BYTES + 2*DATA_BYTES + 1 + ID_W + DEST_W + USER_W;
	localparam int NUM_PKTS   = 200;
	localparam int MAX_BEATS  = 20;
	localparam int BURST_PKTS = 4;
	// The pipeline holds at most three beats, so this is far more than a drain needs
	localparam int DRAIN_CYCLES = 100;
	// Worst case of four cycles per beat, plus room for the burst and phase 2
	localparam int TIMEOUT_CYCLES = NUM_PKTS * MAX_BEATS * 4 + 2000;

	logic                       i_aclk;
	logic                       i_aresetn;
	logic                       i_s_tvalid;
	logic                       o_s_tready;
	logic [8*DATA_BYTES-1:0]    i_s_tdata;
	logic [DATA_BYTES-1:0]      i_s_tkeep;
	logic [DATA_BYTES-1:0]      i_s_tstrb;
	logic                       i_s_tlast;
	logic [ID_W-1:0]            i_s_tid;
	logic [DEST_W-1:0]          i_s_tdest;
	logic [USER_W-1:0]          i_s_tuser;
	logic                       o_m_tvalid;
	logic                       i_m_tready;
	logic [8*DATA_BYTES-1:0]    o_m_tdata;
	logic [DATA_BYTES-1:0]      o_m_tkeep;
	logic [DATA_BYTES-1:0]      o_m_tstrb;
	logic                       o_m_tlast;
	logic [ID_W-1:0]            o_m_tid;
	logic [DEST_W-1:0]          o_m_tdest;
	logic [USER_W-1:0]          o_m_tuser;
	logic [15:0]                o_m_tlen;
	logic                       o_m_tlen_err;
	logic [ROUTE_W-1:0]         i_route_sel;
	logic [15:0]                o_in_bytecount;
	logic [3:0]                 o_in_err;
	logic [3:0]                 o_out_err;

	integer seed = 6178;
	int     err_cnt = 0;
	int     check_cnt = 0;
	int     cycle_cnt = 0;

	// Reference model state fed by the slave handshake
	logic [BEAT_W-1:0] exp_beats[$];
	int                exp_lens[$];
	int                exp_cycles[$];
	int                run_len;
	int                route_count;
	bit                in_fired;
	bit                check_latency;

	// Packet generator state
	int                pkt_left;
	int                pkts_started;
	logic [ID_W-1:0]   pkt_id;
	logic [DEST_W-1:0] pkt_dest;

	axis_policer_top dut0 (
		.i_aclk         (i_aclk),
		.i_aresetn      (i_aresetn),
		.i_s_tvalid     (i_s_tvalid),
		.o_s_tready     (o_s_tready),
		.i_s_tdata      (i_s_tdata),
		.i_s_tkeep      (i_s_tkeep),
		.i_s_tstrb      (i_s_tstrb),
		.i_s_tlast      (i_s_tlast),
		.i_s_tid        (i_s_tid),
		.i_s_tdest      (i_s_tdest),
		.i_s_tuser      (i_s_tuser),
		.o_m_tvalid     (o_m_tvalid),
		.i_m_tready     (i_m_tready),
		.o_m_tdata      (o_m_tdata),
		.o_m_tkeep      (o_m_tkeep),
		.o_m_tstrb      (o_m_tstrb),
		.o_m_tlast      (o_m_tlast),
		.o_m_tid        (o_m_tid),
		.o_m_tdest      (o_m_tdest),
		.o_m_tuser      (o_m_tuser),
		.o_m_tlen       (o_m_tlen),
		.o_m_tlen_err   (o_m_tlen_err),
		.i_route_sel    (i_route_sel),
		.o_in_bytecount (o_in_bytecount),
		.o_in_err       (o_in_err),
		.o_out_err      (o_out_err)
	);

	always #5 i_aclk = ~i_aclk;

	// Cycle count doubles as the time base for the latency check
	always @(posedge i_aclk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	function automatic int pick_in_range(input int lo, input int hi);
		return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	// A byte is payload only when both TKEEP and TSTRB are high
	function automatic int count_bytes(input logic [DATA_BYTES-1:0] keep,
		input logic [DATA_BYTES-1:0] strb);
		int n;
		n = 0;
		for (int b = 0; b < DATA_BYTES; b++)
		begin
			if (keep[b] && strb[b])
				n++;
		end
		return n;
	endfunction

	task automatic drive_idle();
		i_s_tvalid = 1'b0;
		i_s_tdata  = '0;
		i_s_tkeep  = '0;
		i_s_tstrb  = '0;
		i_s_tlast  = 1'b0;
		i_s_tid    = '0;
		i_s_tdest  = '0;
		i_s_tuser  = '0;
	endtask

	task automatic load_full_beat();
		logic [31:0] r;
		r = $random(seed);
		i_s_tvalid = 1'b1;
		i_s_tdata  = r[8*DATA_BYTES-1:0];
		i_s_tkeep  = '1;
		i_s_tstrb  = '1;
		i_s_tlast  = 1'b0;
		i_s_tid    = '0;
		i_s_tdest  = '0;
		i_s_tuser  = '0;
	endtask

	// Ends on the falling edge where reset is released, optionally with TVALID already up
	task automatic reset_dut(input bit valid_at_release);
		@(negedge i_aclk);
		i_aresetn  = 1'b0;
		i_m_tready = 1'b0;
		drive_idle();
		repeat (4) @(negedge i_aclk);
		i_aresetn = 1'b1;
		if (valid_at_release)
		begin
			load_full_beat();
			i_s_tlast = 1'b1;
		end
		in_fired    = 1'b0;
		run_len     = 0;
		route_count = 0;
		pkt_left    = 0;
	endtask

	////////////////////////////////////////
	// Stimulus and model
	////////////////////////////////////////

	// Holds a stalled beat, else presents the next beat or a gap
	task automatic source_step(input int idle_pct, input int pkt_limit);
		logic [31:0] r;
		if (!(i_s_tvalid && !in_fired))
		begin
			if ((pkt_left == 0 && pkts_started >= pkt_limit) || pick_in_range(0, 99) < idle_pct)
				drive_idle();
			else
			begin
				// Route and sidebands only change on a packet boundary
				if (pkt_left == 0)
				begin
					pkt_left = pick_in_range(1, MAX_BEATS);
					pkts_started++;
					r = $random(seed);
					if (pick_in_range(0, 3) == 0)
						i_route_sel = r[ROUTE_W-1:0];
					r = $random(seed);
					if (pick_in_range(0, 1) == 0)
						{pkt_dest, pkt_id} = i_route_sel;
					else
						{pkt_dest, pkt_id} = r[ROUTE_W-1:0];
				end
				r = $random(seed);
				i_s_tdata  = r[8*DATA_BYTES-1:0];
				r = $random(seed);
				i_s_tkeep  = r[DATA_BYTES-1:0];
				i_s_tstrb  = r[DATA_BYTES-1:0] & r[2*DATA_BYTES-1:DATA_BYTES];
				i_s_tuser  = r[31 -: USER_W];
				i_s_tlast  = (pkt_left == 1);
				i_s_tid    = pkt_id;
				i_s_tdest  = pkt_dest;
				i_s_tvalid = 1'b1;
				pkt_left--;
			end
		end
	endtask

	task automatic check_output();
		logic [BEAT_W-1:0]       beat;
		logic [8*DATA_BYTES-1:0] e_data;
		logic [DATA_BYTES-1:0]   e_keep;
		logic [DATA_BYTES-1:0]   e_strb;
		logic                    e_last;
		logic [ID_W-1:0]         e_id;
		logic [DEST_W-1:0]       e_dest;
		logic [USER_W-1:0]       e_user;
		int                      e_len;
		int                      e_cycle;
		if (exp_beats.size() == 0)
		begin
			err_cnt++;
			$display("ERROR at %0t ns: output beat appeared with no input beat left", $time);
		end
		else
		begin
			beat    = exp_beats.pop_front();
			e_len   = exp_lens.pop_front();
			e_cycle = exp_cycles.pop_front();
			{e_data, e_keep, e_strb, e_last, e_id, e_dest, e_user} = beat;
			check_value("o_m_tdata", o_m_tdata, e_data);
			check_value("o_m_tkeep", o_m_tkeep, e_keep);
			check_value("o_m_tstrb", o_m_tstrb, e_strb);
			check_value("o_m_tlast", o_m_tlast, e_last);
			check_value("o_m_tid", o_m_tid, e_id);
			check_value("o_m_tdest", o_m_tdest, e_dest);
			check_value("o_m_tuser", o_m_tuser, e_user);
			check_value("o_m_tlen", o_m_tlen, e_len);
			check_value("o_m_tlen_err", o_m_tlen_err,
				e_last && (e_len < MIN_PKT || e_len > MAX_PKT));
			if (check_latency)
				check_value("beat latency", cycle_cnt - e_cycle, 2);
		end
	endtask

	// Runs one clock cycle, taking handshakes after driving and before the rising edge
	task automatic run_cycle(input int idle_pct, input int pkt_limit, input int ready_pct);
		int bytes;
		@(negedge i_aclk);
		if (in_fired)
			check_value("o_in_bytecount", o_in_bytecount, route_count);
		source_step(idle_pct, pkt_limit);
		i_m_tready = (pick_in_range(0, 99) < ready_pct);
		in_fired = i_s_tvalid && o_s_tready;
		if (in_fired)
		begin
			exp_beats.push_back({i_s_tdata, i_s_tkeep, i_s_tstrb, i_s_tlast,
				i_s_tid, i_s_tdest, i_s_tuser});
			exp_cycles.push_back(cycle_cnt);
			bytes = count_bytes(i_s_tkeep, i_s_tstrb);
			run_len += bytes;
			// The length rides only on the last beat
			exp_lens.push_back(i_s_tlast ? run_len : 0);
			if (i_s_tlast)
				run_len = 0;
			if ({i_s_tdest, i_s_tid} == i_route_sel)
				route_count = i_s_tlast ? 0 : route_count + bytes;
		end
		if (o_m_tvalid && i_m_tready)
			check_output();
	endtask

	// Keeps the sink running with no new input until every accepted beat has come out
	task automatic drain_pipeline(input int ready_pct);
		int n;
		n = 0;
		while (exp_beats.size() != 0 && n < DRAIN_CYCLES)
		begin
			run_cycle(0, 0, ready_pct);
			n++;
		end
		check_value("input beats left", exp_beats.size(), 0);
	endtask

	////////////////////////////////////////
	// Protocol violations
	////////////////////////////////////////

	// Back-pressure until the slice drops its ready with a beat waiting
	task automatic fill_until_stall();
		int n;
		n = 0;
		i_m_tready = 1'b0;
		load_full_beat();
		while (o_s_tready && n < 8)
		begin
			@(negedge i_aclk);
			load_full_beat();
			n++;
		end
		if (o_s_tready)
		begin
			err_cnt++;
			$display("ERROR at %0t ns: o_s_tready never dropped under back-pressure", $time);
		end
	endtask

	task automatic expect_only_flag(input int bit_pos);
		check_value("o_in_err", o_in_err, 64'd1 << bit_pos);
	endtask

	task automatic inject_unstable();
		reset_dut(1'b0);
		@(negedge i_aclk);
		fill_until_stall();
		// Let the monitor see one stalled edge before the data moves
		@(negedge i_aclk);
		i_s_tdata[7:0] = ~i_s_tdata[7:0];
		repeat (2) @(negedge i_aclk);
		expect_only_flag(axis_pkg::ERR_UNSTABLE);
	endtask

	task automatic inject_reserved();
		reset_dut(1'b0);
		@(negedge i_aclk);
		i_m_tready = 1'b1;
		load_full_beat();
		i_s_tkeep = 4'b0011;
		i_s_tstrb = 4'b0110;
		i_s_tlast = 1'b1;
		@(negedge i_aclk);
		drive_idle();
		repeat (2) @(negedge i_aclk);
		expect_only_flag(axis_pkg::ERR_RESERVED);
	endtask

	task automatic inject_long_stall();
		reset_dut(1'b0);
		@(negedge i_aclk);
		fill_until_stall();
		repeat (MAX_STALL + 5) @(negedge i_aclk);
		expect_only_flag(axis_pkg::ERR_STALL);
	endtask

	task automatic inject_reset_valid();
		reset_dut(1'b1);
		i_m_tready = 1'b1;
		// First edge stalls since ready is still low, the second one transfers
		repeat (2) @(negedge i_aclk);
		drive_idle();
		repeat (2) @(negedge i_aclk);
		expect_only_flag(axis_pkg::ERR_RESET_VALID);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		i_aclk        = 1'b0;
		i_aresetn     = 1'b0;
		i_m_tready    = 1'b0;
		i_route_sel   = '0;
		check_latency = 1'b0;
		pkts_started  = 0;
		drive_idle();

		reset_dut(1'b0);
		check_value("o_s_tready", o_s_tready, 0);
		check_value("o_m_tvalid", o_m_tvalid, 0);
		check_value("o_in_bytecount", o_in_bytecount, 0);
		check_value("o_in_err", o_in_err, 0);
		check_value("o_out_err", o_out_err, 0);
		@(negedge i_aclk);
		check_value("o_s_tready", o_s_tready, 1);

		// Phase 1 with random gaps and random back-pressure
		while (pkts_started < NUM_PKTS || pkt_left != 0 || i_s_tvalid)
			run_cycle(20, NUM_PKTS, 70);
		drain_pipeline(70);

		// Back to back burst into an empty pipeline with the sink always ready
		pkts_started  = 0;
		check_latency = 1'b1;
		while (pkts_started < BURST_PKTS || pkt_left != 0 || i_s_tvalid)
			run_cycle(0, BURST_PKTS, 100);
		drain_pipeline(100);
		check_latency = 1'b0;

		check_value("o_in_err", o_in_err, 0);
		check_value("o_out_err", o_out_err, 0);

		// Phase 2 runs each violation after its own reset
		inject_unstable();
		inject_reserved();
		inject_long_stall();
		inject_reset_valid();

		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
